// ==== cpu.f ====
hdl/cpu_pkg.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/sequencer.sv
hdl/cpu_core.sv
tb/tb_clock.sv
tb/cpu_tb.sv

// ==== hdl/alu.sv ====
`timescale 1ns/1ns

module alu
(
    input  cpu_pkg::opcode_t             opcode,
    input  logic [cpu_pkg::data_w-1:0]   a,
    input  logic [cpu_pkg::data_w-1:0]   b,
    input  logic                        fa,
    input  logic                        fb,
    input  logic [cpu_pkg::imm_w-1:0]    imm,
    input  logic                        half_sel,
    output logic [cpu_pkg::data_w-1:0]   result,
    output logic                        flag_result
);

    logic [cpu_pkg::data_w-1:0] sum;
    logic [cpu_pkg::data_w-1:0] diff;
    logic [cpu_pkg::data_w-1:0] imm_value;

    // wraps modulo 2^64
    assign sum = a + b;
    assign diff = a - b;

    // upper half load keeps the low half of b underneath
    always_comb
    begin
        if (half_sel)
            imm_value = {imm, b[cpu_pkg::data_w-cpu_pkg::imm_w-1:0]};
        else
            imm_value = {{(cpu_pkg::data_w-cpu_pkg::imm_w){1'b0}}, imm};
    end

    // register result
    always_comb
    begin
        case (opcode)
            cpu_pkg::op_add:
                result = sum;
            cpu_pkg::op_sub:
                result = diff;
            cpu_pkg::op_and:
                result = a & b;
            cpu_pkg::op_or:
                result = a | b;
            cpu_pkg::op_xor:
                result = a ^ b;
            cpu_pkg::op_loadi:
                result = imm_value;
            cpu_pkg::op_getf:
                result = {{(cpu_pkg::data_w-1){1'b0}}, fa};
            default:
                result = '0;
        endcase
    end

    // flag result
    always_comb
    begin
        case (opcode)
            cpu_pkg::op_eq:
                flag_result = (a == b);
            cpu_pkg::op_ltu:
                flag_result = (a < b);
            cpu_pkg::op_fand:
                flag_result = fa & fb;
            default:
                flag_result = 1'b0;
        endcase
    end

endmodule

// ==== hdl/cpu_core.sv ====
`timescale 1ns/1ns

module cpu_core
(
    input  logic                       clock,
    input  logic                       rst_n,
    input  logic                       mem_ready,
    input  logic [cpu_pkg::data_w-1:0]  mem_rdata,
    output logic                       mem_valid,
    output logic                       mem_write,
    output logic [cpu_pkg::addr_w-1:0]  mem_addr,
    output logic [cpu_pkg::data_w-1:0]  mem_wdata,
    output logic                       halted
);

    logic [cpu_pkg::reg_idx_w-1:0] ra_idx;
    logic [cpu_pkg::reg_idx_w-1:0] rb_idx;
    logic [cpu_pkg::reg_idx_w-1:0] rd_idx;
    logic reg_we;
    logic flag_we;
    logic [cpu_pkg::data_w-1:0] ra_data;
    logic [cpu_pkg::data_w-1:0] rb_data;
    logic fa;
    logic fb;
    cpu_pkg::opcode_t opcode;
    logic [cpu_pkg::imm_w-1:0] imm;
    logic half_sel;
    logic [cpu_pkg::data_w-1:0] result;
    logic flag_result;

    sequencer u_sequencer (
        .clock     (clock),
        .rst_n     (rst_n),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata),
        .ra_data   (ra_data),
        .rb_data   (rb_data),
        .fa        (fa),
        .mem_valid (mem_valid),
        .mem_write (mem_write),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .ra_idx    (ra_idx),
        .rb_idx    (rb_idx),
        .rd_idx    (rd_idx),
        .reg_we    (reg_we),
        .flag_we   (flag_we),
        .opcode    (opcode),
        .imm       (imm),
        .half_sel  (half_sel),
        .halted    (halted)
    );

    reg_file u_reg_file (
        .clock   (clock),
        .rst_n   (rst_n),
        .ra_idx  (ra_idx),
        .rb_idx  (rb_idx),
        .rd_idx  (rd_idx),
        .reg_we  (reg_we),
        .flag_we (flag_we),
        .wdata   (result),
        .fwdata  (flag_result),
        .ra_data (ra_data),
        .rb_data (rb_data),
        .fa      (fa),
        .fb      (fb)
    );

    // operands come straight from the two read ports
    alu u_alu (
        .opcode      (opcode),
        .a           (ra_data),
        .b           (rb_data),
        .fa          (fa),
        .fb          (fb),
        .imm         (imm),
        .half_sel    (half_sel),
        .result      (result),
        .flag_result (flag_result)
    );

endmodule

// ==== hdl/cpu_pkg.sv ====
package cpu_pkg;

    // datapath and memory widths
    localparam int data_w = 64;
    localparam int addr_w = 16;
    localparam int reg_idx_w = 3;
    localparam int num_regs = 2 ** reg_idx_w;
    localparam int imm_w = 32;
    localparam int opcode_w = 6;

    // instruction field positions
    localparam int ra_lsb = 6;
    localparam int rb_lsb = 9;
    localparam int rd_lsb = 12;
    localparam int half_bit = 15;
    localparam int imm_lsb = 32;

    // codes below 8 target a general register, 8 and up target a flag
    typedef enum logic [opcode_w-1:0] {
        op_add   = 6'd0,
        op_sub   = 6'd1,
        op_and   = 6'd2,
        op_or    = 6'd3,
        op_xor   = 6'd4,
        op_loadi = 6'd5,
        op_getf  = 6'd6,
        op_store = 6'd7,
        op_eq    = 6'd8,
        op_ltu   = 6'd9,
        op_fand  = 6'd10,
        op_jmpf  = 6'd11,
        op_halt  = 6'd12
    } opcode_t;

    // sequencer states
    typedef enum logic [1:0] {
        s_fetch = 2'd0,
        s_exec  = 2'd1,
        s_store = 2'd2,
        s_halt  = 2'd3
    } seq_state_t;

endpackage

// ==== hdl/reg_file.sv ====
`timescale 1ns/1ns

module reg_file
(
    input  logic                         clock,
    input  logic                         rst_n,
    input  logic [cpu_pkg::reg_idx_w-1:0] ra_idx,
    input  logic [cpu_pkg::reg_idx_w-1:0] rb_idx,
    input  logic [cpu_pkg::reg_idx_w-1:0] rd_idx,
    input  logic                         reg_we,
    input  logic                         flag_we,
    input  logic [cpu_pkg::data_w-1:0]    wdata,
    input  logic                         fwdata,
    output logic [cpu_pkg::data_w-1:0]    ra_data,
    output logic [cpu_pkg::data_w-1:0]    rb_data,
    output logic                         fa,
    output logic                         fb
);

    logic [cpu_pkg::data_w-1:0] regs [cpu_pkg::num_regs];
    logic [cpu_pkg::num_regs-1:0] flags;

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < cpu_pkg::num_regs; i++)
                regs[i] <= '0;
            flags <= '0;
        end
        else
        begin
            if (reg_we)
                regs[rd_idx] <= wdata;
            if (flag_we)
                flags[rd_idx] <= fwdata;
        end
    end

    // both read ports see registers and flags
    assign ra_data = regs[ra_idx];
    assign rb_data = regs[rb_idx];
    assign fa = flags[ra_idx];
    assign fb = flags[rb_idx];

    // the destination must be known whenever something is written
    a_write_idx_known: assert property (
        @(posedge clock) disable iff (!rst_n)
        (reg_we || flag_we) |-> !$isunknown(rd_idx)
    );

endmodule

// ==== hdl/sequencer.sv ====
`timescale 1ns/1ns

module sequencer
(
    input  logic                          clock,
    input  logic                          rst_n,
    input  logic                          mem_ready,
    input  logic [cpu_pkg::data_w-1:0]     mem_rdata,
    input  logic [cpu_pkg::data_w-1:0]     ra_data,
    input  logic [cpu_pkg::data_w-1:0]     rb_data,
    input  logic                          fa,
    output logic                          mem_valid,
    output logic                          mem_write,
    output logic [cpu_pkg::addr_w-1:0]     mem_addr,
    output logic [cpu_pkg::data_w-1:0]     mem_wdata,
    output logic [cpu_pkg::reg_idx_w-1:0]  ra_idx,
    output logic [cpu_pkg::reg_idx_w-1:0]  rb_idx,
    output logic [cpu_pkg::reg_idx_w-1:0]  rd_idx,
    output logic                          reg_we,
    output logic                          flag_we,
    output cpu_pkg::opcode_t               opcode,
    output logic [cpu_pkg::imm_w-1:0]      imm,
    output logic                          half_sel,
    output logic                          halted
);

    cpu_pkg::seq_state_t state;
    cpu_pkg::seq_state_t state_next;
    logic [cpu_pkg::addr_w-1:0] pc;
    logic [cpu_pkg::data_w-1:0] ir;
    logic valid_q;
    logic accept;
    logic exec;

    assign accept = valid_q && mem_ready;
    assign exec = (state == cpu_pkg::s_exec);

    // instruction fields
    assign opcode = cpu_pkg::opcode_t'(ir[cpu_pkg::opcode_w-1:0]);
    assign ra_idx = ir[cpu_pkg::ra_lsb +: cpu_pkg::reg_idx_w];
    assign rb_idx = ir[cpu_pkg::rb_lsb +: cpu_pkg::reg_idx_w];
    assign rd_idx = ir[cpu_pkg::rd_lsb +: cpu_pkg::reg_idx_w];
    assign half_sel = ir[cpu_pkg::half_bit];
    assign imm = ir[cpu_pkg::imm_lsb +: cpu_pkg::imm_w];

    // memory port, store address and data come from the source registers
    assign mem_valid = valid_q;
    assign mem_write = (state == cpu_pkg::s_store);
    assign mem_addr = mem_write ? rb_data[cpu_pkg::addr_w-1:0] : pc;
    assign mem_wdata = mem_write ? ra_data : '0;
    assign halted = (state == cpu_pkg::s_halt);

    always_comb
    begin
        state_next = state;
        case (state)
            cpu_pkg::s_fetch:
            begin
                if (accept)
                    state_next = cpu_pkg::s_exec;
            end
            cpu_pkg::s_exec:
            begin
                if (opcode == cpu_pkg::op_store)
                    state_next = cpu_pkg::s_store;
                else if (opcode == cpu_pkg::op_halt)
                    state_next = cpu_pkg::s_halt;
                else
                    state_next = cpu_pkg::s_fetch;
            end
            cpu_pkg::s_store:
            begin
                if (accept)
                    state_next = cpu_pkg::s_fetch;
            end
            default:
                state_next = cpu_pkg::s_halt;
        endcase
    end

    // write strobes only in the execute cycle
    always_comb
    begin
        reg_we = 1'b0;
        flag_we = 1'b0;
        if (exec)
        begin
            case (opcode)
                cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_and, cpu_pkg::op_or,
                cpu_pkg::op_xor, cpu_pkg::op_loadi, cpu_pkg::op_getf:
                    reg_we = 1'b1;
                cpu_pkg::op_eq, cpu_pkg::op_ltu, cpu_pkg::op_fand:
                    flag_we = 1'b1;
                default:
                    reg_we = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= cpu_pkg::s_fetch;
            valid_q <= 1'b0;
            pc <= '0;
            ir <= '0;
        end
        else
        begin
            state <= state_next;
            // request whenever the next state needs the memory
            valid_q <= (state_next == cpu_pkg::s_fetch) || (state_next == cpu_pkg::s_store);
            if (state == cpu_pkg::s_fetch && accept)
                ir <= mem_rdata;
            if (exec && opcode == cpu_pkg::op_jmpf && fa)
                pc <= imm[cpu_pkg::addr_w-1:0];
            else if (exec && opcode != cpu_pkg::op_store && opcode != cpu_pkg::op_halt)
                pc <= pc + 1'b1;
            else if (mem_write && accept)
                pc <= pc + 1'b1;
        end
    end

    a_req_stable: assert property (
        @(posedge clock) disable iff (!rst_n)
        (mem_valid && !mem_ready) |=>
            (mem_valid && $stable(mem_write) && $stable(mem_addr) && $stable(mem_wdata))
    );

    a_one_strobe: assert property (
        @(posedge clock) disable iff (!rst_n)
        !(reg_we && flag_we)
    );

    a_quiet_halt: assert property (
        @(posedge clock) disable iff (!rst_n)
        halted |-> !mem_valid
    );

endmodule

// ==== tb/cpu_tb.sv ====
`timescale 1ns/1ns

module cpu_tb;

    localparam int body_len = 160;
    localparam int reset_limit = 64;
    localparam int run_limit = 20000;
    localparam int stall_limit = 200;
    localparam int quiet_cycles = 64;
    localparam int model_limit = 10000;

    logic clock;
    logic rst_n;
    logic mem_ready;
    logic [cpu_pkg::data_w-1:0] mem_rdata;
    logic mem_valid;
    logic mem_write;
    logic [cpu_pkg::addr_w-1:0] mem_addr;
    logic [cpu_pkg::data_w-1:0] mem_wdata;
    logic halted;

    logic [cpu_pkg::data_w-1:0] mem [0:65535];
    logic [cpu_pkg::data_w-1:0] model_mem [0:65535];
    logic [cpu_pkg::addr_w-1:0] exp_fetch [$];
    logic [cpu_pkg::addr_w-1:0] exp_addr [$];
    logic [cpu_pkg::data_w-1:0] exp_data [$];
    integer seed = 32'h3ec5cdf6;
    int errors;
    int checks;
    int gen_pc;
    int cycles;
    int idle;
    bit timed_out;
    bit first_done;

    tb_clock u_clock (
        .clock (clock),
        .rst_n (rst_n)
    );

    cpu_core uut (
        .clock     (clock),
        .rst_n     (rst_n),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata),
        .mem_valid (mem_valid),
        .mem_write (mem_write),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .halted    (halted)
    );

    // the memory answers reads in the same cycle
    assign mem_rdata = mem[mem_addr];

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (expected !== actual)
        begin
            errors++;
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    function automatic logic [63:0] make_instr(input logic [5:0] op, input logic [2:0] a,
                                               input logic [2:0] b, input logic [2:0] d,
                                               input logic half, input logic [31:0] imm);
        make_instr = {imm, 16'h0000, half, d, b, a, op};
    endfunction

    task automatic put_instr(input logic [63:0] instr);
        mem[gen_pc] = instr;
        model_mem[gen_pc] = instr;
        gen_pc++;
    endtask

    task automatic fill_memory();
        logic [15:0] addr;
        for (int i = 0; i < 65536; i++)
        begin
            addr = i[15:0];
            mem[i] = {addr, ~addr, addr ^ 16'ha5a5, {addr[7:0], addr[15:8]}};
            model_mem[i] = mem[i];
        end
    endtask

    // r7 only ever holds a store address well above the program
    task automatic generate_program();
        logic [31:0] rnd;
        logic [31:0] rnd2;
        logic [31:0] imm;
        logic [2:0] rd;
        int kind;
        int target;
        int nop_code;
        gen_pc = 0;
        while (gen_pc < body_len)
        begin
            rnd = $random(seed);
            rnd2 = $random(seed);
            imm = $random(seed);
            kind = rnd[15:12];
            rd = (rnd[11:9] == 3'd7) ? 3'd6 : rnd[11:9];
            case (kind)
                0, 1, 2, 3, 4:
                    put_instr(make_instr(kind[5:0], rnd[2:0], rnd[5:3], rd, 1'b0, imm));
                5, 6:
                    put_instr(make_instr(cpu_pkg::op_loadi, rnd[2:0], rnd[5:3], rd,
                                         rnd[16], imm));
                7:
                    put_instr(make_instr(cpu_pkg::op_getf, rnd[2:0], rnd[5:3], rd, 1'b0, imm));
                8:
                    put_instr(make_instr(cpu_pkg::op_eq, rnd[2:0], rnd[5:3], rnd[8:6], 1'b0, imm));
                9:
                    put_instr(make_instr(cpu_pkg::op_ltu, rnd[2:0], rnd[5:3], rnd[8:6], 1'b0, imm));
                10:
                    put_instr(make_instr(cpu_pkg::op_fand, rnd[2:0], rnd[5:3], rnd[8:6], 1'b0,
                                         imm));
                11, 12:
                begin
                    // forward only, at most to the start of the dump sequence
                    target = gen_pc + 1 + int'(rnd2[15:0]) % (body_len - gen_pc);
                    put_instr(make_instr(cpu_pkg::op_jmpf, rnd[2:0], rnd[5:3], rd, 1'b0,
                                         {imm[31:16], target[15:0]}));
                end
                13:
                begin
                    if (gen_pc + 1 < body_len)
                    begin
                        put_instr(make_instr(cpu_pkg::op_loadi, 3'd0, 3'd0, 3'd7, 1'b0,
                                             {16'h0000, 4'h8, imm[11:0]}));
                        put_instr(make_instr(cpu_pkg::op_store, rnd[2:0], 3'd7, 3'd0, 1'b0, imm));
                    end
                    else
                        put_instr(make_instr(6'd13, 3'd0, 3'd0, 3'd0, 1'b0, imm));
                end
                default:
                begin
                    nop_code = 13 + int'(rnd2[15:0]) % 51;
                    put_instr(make_instr(nop_code[5:0], rnd[2:0], rnd[5:3], rnd[8:6], rnd[16],
                                         imm));
                end
            endcase
        end
        // dump every register, then every flag through r0
        for (int r = 0; r < 8; r++)
            put_instr(make_instr(cpu_pkg::op_store, r[2:0], 3'd7, 3'd0, 1'b0, 32'h0));
        for (int f = 0; f < 8; f++)
        begin
            put_instr(make_instr(cpu_pkg::op_getf, f[2:0], 3'd0, 3'd0, 1'b0, 32'h0));
            put_instr(make_instr(cpu_pkg::op_store, 3'd0, 3'd7, 3'd0, 1'b0, 32'h0));
        end
        put_instr(make_instr(cpu_pkg::op_halt, 3'd0, 3'd0, 3'd0, 1'b0, 32'h0));
    endtask

    // instruction-set model, records every fetch address and every store
    task automatic run_model();
        cpu_pkg::opcode_t op;
        logic [63:0] ins;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] regs [8];
        logic [7:0] flags;
        logic [15:0] pc;
        logic [15:0] pc_next;
        logic [2:0] ai;
        logic [2:0] bi;
        logic [2:0] di;
        logic [31:0] imm;
        bit done;
        int steps;
        for (int i = 0; i < 8; i++)
            regs[i] = '0;
        flags = '0;
        pc = '0;
        done = 1'b0;
        steps = 0;
        while (!done && steps < model_limit)
        begin
            ins = model_mem[pc];
            exp_fetch.push_back(pc);
            op = cpu_pkg::opcode_t'(ins[5:0]);
            ai = ins[8:6];
            bi = ins[11:9];
            di = ins[14:12];
            imm = ins[63:32];
            a = regs[ai];
            b = regs[bi];
            pc_next = pc + 16'd1;
            case (op)
                cpu_pkg::op_add: regs[di] = a + b;
                cpu_pkg::op_sub: regs[di] = a - b;
                cpu_pkg::op_and: regs[di] = a & b;
                cpu_pkg::op_or: regs[di] = a | b;
                cpu_pkg::op_xor: regs[di] = a ^ b;
                cpu_pkg::op_loadi: regs[di] = ins[15] ? {imm, b[31:0]} : {32'h0, imm};
                cpu_pkg::op_getf: regs[di] = {63'h0, flags[ai]};
                cpu_pkg::op_eq: flags[di] = (a == b);
                cpu_pkg::op_ltu: flags[di] = (a < b);
                cpu_pkg::op_fand: flags[di] = flags[ai] & flags[bi];
                cpu_pkg::op_store:
                begin
                    exp_addr.push_back(b[15:0]);
                    exp_data.push_back(a);
                    model_mem[b[15:0]] = a;
                end
                cpu_pkg::op_jmpf:
                begin
                    if (flags[ai])
                        pc_next = imm[15:0];
                end
                cpu_pkg::op_halt: done = 1'b1;
                default: ;
            endcase
            pc = pc_next;
            steps++;
        end
        if (!done)
        begin
            errors++;
            $display("model did not reach a halt instruction");
        end
    endtask

    always @(posedge clock)
        mem_ready <= ($random(seed) & 3) != 0;

    // every accepted transfer is compared in order
    always @(posedge clock)
    begin
        if (rst_n && mem_valid && mem_ready)
        begin
            if (!first_done)
            begin
                first_done = 1'b1;
                check_value("first request write", 0, mem_write);
                check_value("first request address", 0, mem_addr);
            end
            if (mem_write)
            begin
                mem[mem_addr] <= mem_wdata;
                if (exp_addr.size() == 0)
                begin
                    errors++;
                    $display("store to address %h that the model never made", mem_addr);
                end
                else
                begin
                    check_value("store address", exp_addr.pop_front(), mem_addr);
                    check_value("store data", exp_data.pop_front(), mem_wdata);
                end
            end
            else if (exp_fetch.size() == 0)
            begin
                errors++;
                $display("fetch from address %h after the program should have halted", mem_addr);
            end
            else
                check_value("fetch address", exp_fetch.pop_front(), mem_addr);
        end
    end

    initial
    begin
        errors = 0;
        checks = 0;
        timed_out = 1'b0;
        first_done = 1'b0;
        mem_ready = 1'b0;
        fill_memory();
        generate_program();
        run_model();

        cycles = 0;
        do
        begin
            @(posedge clock);
            cycles++;
            // outputs are settled once the first edge has seen reset
            if (!rst_n && cycles > 1)
            begin
                check_value("mem_valid in reset", 0, mem_valid);
                check_value("halted in reset", 0, halted);
            end
            if (cycles > reset_limit)
            begin
                errors++;
                timed_out = 1'b1;
                $display("reset was not released within %0d cycles", reset_limit);
            end
        end
        while (!rst_n && !timed_out);
        check_value("mem_valid in first cycle", 0, mem_valid);
        check_value("halted in first cycle", 0, halted);

        cycles = 0;
        idle = 0;
        while (!halted && !timed_out)
        begin
            @(posedge clock);
            cycles++;
            if (mem_valid && mem_ready)
                idle = 0;
            else
                idle++;
            if (idle > stall_limit || cycles > run_limit)
            begin
                errors++;
                timed_out = 1'b1;
                $display("core stalled or did not halt after %0d cycles", cycles);
            end
        end

        if (!timed_out)
        begin
            for (int i = 0; i < quiet_cycles; i++)
            begin
                @(posedge clock);
                check_value("request after halt", 0, mem_valid);
            end
            if (exp_fetch.size() != 0 || exp_addr.size() != 0)
            begin
                errors++;
                $display("%0d fetches and %0d stores of the model never appeared",
                         exp_fetch.size(), exp_addr.size());
            end
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0 && !timed_out)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== tb/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock
(
    output logic clock,
    output logic rst_n
);

    localparam int half_period = 50;
    localparam int reset_cycles = 16;

    initial
    begin
        clock = 1'b0;
        forever
            #half_period clock = ~clock;
    end

    // release on a rising edge so the core sees a clean first cycle
    initial
    begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clock);
        rst_n <= 1'b1;
    end

endmodule
